// File: flist.f
+incdir+include
source/core_pkg.sv
source/core_reset_ctrl.sv
source/req_retime_slice.sv
source/core_top.sv
tests/tb_core_top.sv

// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// --------------------------------------
// Reset sequencing
// --------------------------------------

// Flops per asynchronous reset request synchronizer
`define CORE_SYNC_STAGES    2

// --------------------------------------
// Instruction memory channel
// --------------------------------------
`define CORE_IMEM_AWIDTH    32      // Fetch address
`define CORE_IMEM_BSIZE     3       // Burst length field

// --------------------------------------
// Data memory channel
// --------------------------------------
`define CORE_DMEM_AWIDTH    32      // Load/store address
`define CORE_DMEM_DWIDTH    32      // Store data

// --------------------------------------
// Retimed channel map
// --------------------------------------
`define CORE_CHAN_NUM       2       // One slice per channel
`define CORE_CHAN_IMEM      0       // Decoded through the imem view
`define CORE_CHAN_DMEM      1       // Decoded through the dmem view

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run tb_core_top with Verilator; the verdict comes from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_core_top -f flist.f \
    -Mdir obj_dir -o tb_core_top \
    && ./obj_dir/tb_core_top | tee sim.log \
    || echo "Build or simulation stopped with an error"

grep -q "TEST FAILED" sim.log 2>/dev/null && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log 2>/dev/null || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0

// File: source/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

    // --------------------------------------
    // Memory command encodings
    // --------------------------------------

    // Same code on both channels
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access size, data channel only
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // --------------------------------------
    // Payload sizing
    // --------------------------------------

    // Data view is the widest, so it sets the word size
    localparam int unsigned REQ_PAYLOAD_W = $bits(mem_cmd_e) + $bits(mem_width_e)
                                          + `CORE_DMEM_AWIDTH + `CORE_DMEM_DWIDTH;
    localparam int unsigned IMEM_PAD_W    = REQ_PAYLOAD_W - $bits(mem_cmd_e)
                                          - `CORE_IMEM_AWIDTH - `CORE_IMEM_BSIZE;

    // --------------------------------------
    // Request views
    // --------------------------------------

    typedef struct packed {
        logic [IMEM_PAD_W-1:0]        pad;     // Unused upper bits, zero
        mem_cmd_e                     cmd;     // Fetch is always a read in practice
        logic [`CORE_IMEM_AWIDTH-1:0] addr;
        logic [`CORE_IMEM_BSIZE-1:0]  bl;      // Burst length
    } imem_req_s;

    typedef struct packed {
        mem_cmd_e                     cmd;
        mem_width_e                   width;   // Byte lanes of the access
        logic [`CORE_DMEM_AWIDTH-1:0] addr;
        logic [`CORE_DMEM_DWIDTH-1:0] wdata;   // Don't care on reads
    } dmem_req_s;

    // One slice word, decoded per channel
    typedef union packed {
        imem_req_s imem;
        dmem_req_s dmem;
    } req_payload_u;

endpackage

`default_nettype wire

// File: source/core_reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_reset_ctrl (
    input  logic clk,
    input  logic rst_i,              // Power-up reset, sync, active high
    input  logic soft_rst_i,         // Async request
    input  logic cpu_rst_i,          // Async request
    output logic core_rst_o,         // Sequenced core reset
    output logic core_rdc_qlfy_o,    // Low while core domain is unsafe
    output logic core_rst_status_o   // Core reset, two cycles late
);

    localparam int unsigned STATUS_STAGES = 2;

    // Request synchronizers
    logic [`CORE_SYNC_STAGES-1:0] soft_sync_q;
    logic [`CORE_SYNC_STAGES-1:0] cpu_sync_q;
    logic                         req_sync;      // Combined synchronized request

    // Qualifier adapter
    logic req_dly_q;                             // First step, request delayed
    logic core_rst_q;                            // Second step, the core reset
    logic qlfy_q;

    // Status
    logic [STATUS_STAGES-1:0] status_sync_q;

    // --------------------------------------
    // Request synchronizers
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            soft_sync_q <= '0;
            cpu_sync_q  <= '0;
        end else begin
            soft_sync_q <= {soft_sync_q[`CORE_SYNC_STAGES-2:0], soft_rst_i}; // Shift in at LSB
            cpu_sync_q  <= {cpu_sync_q[`CORE_SYNC_STAGES-2:0], cpu_rst_i};
        end
    end

    // Either source resets the core
    assign req_sync = soft_sync_q[`CORE_SYNC_STAGES-1] | cpu_sync_q[`CORE_SYNC_STAGES-1];

    // --------------------------------------
    // Qualifier adapter
    // --------------------------------------

    // Request drops the qualifier one cycle ahead of the core reset.
    // The qualifier only comes back once request, delay and reset are
    // all clear, one cycle after the core reset releases.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_dly_q  <= 1'b1;                 // Held in reset at power-up
            core_rst_q <= 1'b1;
            qlfy_q     <= 1'b0;
        end else begin
            req_dly_q  <= req_sync;
            core_rst_q <= req_dly_q;            // Rises/falls 3 cycles after input
            qlfy_q     <= ~(req_sync | req_dly_q | core_rst_q);
        end
    end

    assign core_rst_o      = core_rst_q;
    assign core_rdc_qlfy_o = qlfy_q;

    // --------------------------------------
    // Reset status
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            status_sync_q <= '1;                // Reports reset at power-up
        end else begin
            status_sync_q <= {status_sync_q[STATUS_STAGES-2:0], core_rst_q};
        end
    end

    assign core_rst_status_o = status_sync_q[STATUS_STAGES-1];   // Tracks core_rst_o, +2

endmodule

`default_nettype wire

// File: source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_top (
    // Control
    input  logic                         clk,                 // Core clock
    input  logic                         rst_i,               // Power-up reset
    input  logic                         soft_rst_i,          // Async soft reset request
    input  logic                         cpu_rst_i,           // Async CPU reset request
    output logic                         core_rst_o,          // Core reset
    output logic                         core_rdc_qlfy_o,     // Core RDC qualifier
    output logic                         core_rst_status_o,   // Synchronized reset status

    // Instruction channel, pipeline side
    input  logic                         pipe_imem_req_i,
    input  logic                         pipe_imem_cmd_i,
    input  logic [`CORE_IMEM_AWIDTH-1:0] pipe_imem_addr_i,
    input  logic [`CORE_IMEM_BSIZE-1:0]  pipe_imem_bl_i,
    output logic                         pipe_imem_ack_o,

    // Instruction channel, memory side
    output logic                         imem_req_o,
    output logic                         imem_cmd_o,
    output logic [`CORE_IMEM_AWIDTH-1:0] imem_addr_o,
    output logic [`CORE_IMEM_BSIZE-1:0]  imem_bl_o,
    input  logic                         imem_ack_i,

    // Data channel, pipeline side
    input  logic                         pipe_dmem_req_i,
    input  logic                         pipe_dmem_cmd_i,
    input  logic [1:0]                   pipe_dmem_width_i,
    input  logic [`CORE_DMEM_AWIDTH-1:0] pipe_dmem_addr_i,
    input  logic [`CORE_DMEM_DWIDTH-1:0] pipe_dmem_wdata_i,
    output logic                         pipe_dmem_ack_o,

    // Data channel, memory side
    output logic                         dmem_req_o,
    output logic                         dmem_cmd_o,
    output logic [1:0]                   dmem_width_o,
    output logic [`CORE_DMEM_AWIDTH-1:0] dmem_addr_o,
    output logic [`CORE_DMEM_DWIDTH-1:0] dmem_wdata_o,
    input  logic                         dmem_ack_i
);

    logic core_rst;                                           // Slice reset

    // Per-channel slice connections, indexed by channel
    logic [`CORE_CHAN_NUM-1:0] up_req;
    logic [`CORE_CHAN_NUM-1:0] up_ack;
    logic [`CORE_CHAN_NUM-1:0] dn_req;
    logic [`CORE_CHAN_NUM-1:0] dn_ack;
    core_pkg::req_payload_u    up_payload [`CORE_CHAN_NUM];
    core_pkg::req_payload_u    dn_payload [`CORE_CHAN_NUM];

    // --------------------------------------
    // Reset sequencing
    // --------------------------------------

    core_reset_ctrl u_reset_ctrl (
        .clk               (clk              ),
        .rst_i             (rst_i            ),
        .soft_rst_i        (soft_rst_i       ),
        .cpu_rst_i         (cpu_rst_i        ),
        .core_rst_o        (core_rst         ),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o  ),
        .core_rst_status_o (core_rst_status_o)
    );

    assign core_rst_o = core_rst;

    // --------------------------------------
    // Pipeline side packing
    // --------------------------------------

    assign up_req[`CORE_CHAN_IMEM] = pipe_imem_req_i;
    assign up_req[`CORE_CHAN_DMEM] = pipe_dmem_req_i;

    always_comb begin
        // Instruction view, padding left at zero
        up_payload[`CORE_CHAN_IMEM]            = '0;
        up_payload[`CORE_CHAN_IMEM].imem.cmd   = core_pkg::mem_cmd_e'(pipe_imem_cmd_i);
        up_payload[`CORE_CHAN_IMEM].imem.addr  = pipe_imem_addr_i;
        up_payload[`CORE_CHAN_IMEM].imem.bl    = pipe_imem_bl_i;
        // Data view fills the whole word
        up_payload[`CORE_CHAN_DMEM].dmem.cmd   = core_pkg::mem_cmd_e'(pipe_dmem_cmd_i);
        up_payload[`CORE_CHAN_DMEM].dmem.width = core_pkg::mem_width_e'(pipe_dmem_width_i);
        up_payload[`CORE_CHAN_DMEM].dmem.addr  = pipe_dmem_addr_i;
        up_payload[`CORE_CHAN_DMEM].dmem.wdata = pipe_dmem_wdata_i;
    end

    assign pipe_imem_ack_o = up_ack[`CORE_CHAN_IMEM];
    assign pipe_dmem_ack_o = up_ack[`CORE_CHAN_DMEM];

    // --------------------------------------
    // Retiming slices
    // --------------------------------------

    for (genvar ch = 0; ch < `CORE_CHAN_NUM; ch++) begin : g_chan
        req_retime_slice u_slice (
            .clk          (clk           ),
            .rst_i        (core_rst      ),  // Held with the core
            .up_req_i     (up_req[ch]    ),
            .up_ack_o     (up_ack[ch]    ),
            .up_payload_i (up_payload[ch]),
            .dn_req_o     (dn_req[ch]    ),
            .dn_ack_i     (dn_ack[ch]    ),
            .dn_payload_o (dn_payload[ch])
        );
    end

    // --------------------------------------
    // Memory side unpacking
    // --------------------------------------

    assign dn_ack[`CORE_CHAN_IMEM] = imem_ack_i;
    assign dn_ack[`CORE_CHAN_DMEM] = dmem_ack_i;

    // Instruction channel, padding dropped
    assign imem_req_o   = dn_req[`CORE_CHAN_IMEM];
    assign imem_cmd_o   = dn_payload[`CORE_CHAN_IMEM].imem.cmd;
    assign imem_addr_o  = dn_payload[`CORE_CHAN_IMEM].imem.addr;
    assign imem_bl_o    = dn_payload[`CORE_CHAN_IMEM].imem.bl;

    // Data channel
    assign dmem_req_o   = dn_req[`CORE_CHAN_DMEM];
    assign dmem_cmd_o   = dn_payload[`CORE_CHAN_DMEM].dmem.cmd;
    assign dmem_width_o = dn_payload[`CORE_CHAN_DMEM].dmem.width;
    assign dmem_addr_o  = dn_payload[`CORE_CHAN_DMEM].dmem.addr;
    assign dmem_wdata_o = dn_payload[`CORE_CHAN_DMEM].dmem.wdata;

endmodule

`default_nettype wire

// File: source/req_retime_slice.sv
`timescale 1ns/1ps
`default_nettype none

module req_retime_slice (
    input  logic                   clk,
    input  logic                   rst_i,          // Core reset, sync, active high
    // Pipeline side
    input  logic                   up_req_i,
    output logic                   up_ack_o,       // High while an entry is free
    input  core_pkg::req_payload_u up_payload_i,
    // Memory side
    output logic                   dn_req_o,       // High while an entry is held
    input  logic                   dn_ack_i,
    output core_pkg::req_payload_u dn_payload_o
);

    localparam logic [1:0] DEPTH = 2'd2;

    core_pkg::req_payload_u buf_q [2];             // Ping-pong entries

    logic       wr_ptr_q;                          // Next entry to fill
    logic       rd_ptr_q;                          // Oldest entry
    logic [1:0] count_q;                           // Entries in use
    logic [1:0] count_nxt;
    logic       up_ack_q;
    logic       up_xfer;                           // Upstream handshake
    logic       dn_xfer;                           // Downstream handshake

    // --------------------------------------
    // Handshakes and occupancy
    // --------------------------------------

    assign up_xfer = up_req_i & up_ack_q;
    assign dn_xfer = dn_req_o & dn_ack_i;

    // Both can fire in one cycle, count then holds
    assign count_nxt = count_q + {1'b0, up_xfer} - {1'b0, dn_xfer};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            up_ack_q <= 1'b0;                      // No accept while in reset
        end else begin
            if (up_xfer) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (dn_xfer) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q  <= count_nxt;
            up_ack_q <= (count_nxt != DEPTH);      // Back-pressure once full
        end
    end

    // --------------------------------------
    // Entry storage
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (up_xfer) begin
            buf_q[wr_ptr_q] <= up_payload_i;
        end
    end

    // --------------------------------------
    // Outputs
    // --------------------------------------

    assign up_ack_o = up_ack_q;                    // Register only, no path from dn_ack_i
    assign dn_req_o = (count_q != 2'd0);

    // Idle payload reads as zero, keeps commands low while empty
    assign dn_payload_o = dn_req_o ? buf_q[rd_ptr_q] : '0;

endmodule

`default_nettype wire

// File: tests/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_core_top;

    localparam int WAIT_LIMIT = 1000;          // Cycles per wait loop
    localparam int IMEM       = `CORE_CHAN_IMEM;
    localparam int DMEM       = `CORE_CHAN_DMEM;
    // Edges counted from the first sample of a reset request
    localparam int QLFY_DLY   = 2;
    localparam int RST_DLY    = 3;
    localparam int STATUS_DLY = 5;
    localparam int ACK_LOW    = 0;
    localparam int ACK_HIGH   = 1;
    localparam int ACK_RANDOM = 2;

    // All request fields of both channels
    typedef struct packed {
        logic                         cmd;
        logic [1:0]                   width;
        logic [`CORE_DMEM_AWIDTH-1:0] addr;
        logic [`CORE_DMEM_DWIDTH-1:0] wdata;
        logic [`CORE_IMEM_BSIZE-1:0]  bl;
    } req_rec_t;

    logic clk, rst_i, soft_rst_i, cpu_rst_i;
    logic core_rst_o, core_rdc_qlfy_o, core_rst_status_o;
    logic pipe_imem_req_i, pipe_imem_cmd_i, pipe_imem_ack_o;
    logic [`CORE_IMEM_AWIDTH-1:0] pipe_imem_addr_i, imem_addr_o;
    logic [`CORE_IMEM_BSIZE-1:0]  pipe_imem_bl_i, imem_bl_o;
    logic imem_req_o, imem_cmd_o, imem_ack_i;
    logic pipe_dmem_req_i, pipe_dmem_cmd_i, pipe_dmem_ack_o;
    logic [1:0]                   pipe_dmem_width_i, dmem_width_o;
    logic [`CORE_DMEM_AWIDTH-1:0] pipe_dmem_addr_i, dmem_addr_o;
    logic [`CORE_DMEM_DWIDTH-1:0] pipe_dmem_wdata_i, dmem_wdata_o;
    logic dmem_req_o, dmem_cmd_o, dmem_ack_i;

    // Scoreboard
    req_rec_t    exp_q  [`CORE_CHAN_NUM][$];   // Accepted but not yet delivered
    int          edge_q [`CORE_CHAN_NUM][$];   // Edge of each acceptance
    int          ack_mode  [`CORE_CHAN_NUM];
    int          full_seen [`CORE_CHAN_NUM];   // Cycles with two pending
    int          cycle_cnt = 0;
    logic        ack_check_en = 1'b0;
    logic        latency_check_en = 1'b0;
    logic [31:0] lfsr_q = 32'h859fa743;

    core_top u_dut (
        .clk (clk), .rst_i (rst_i), .soft_rst_i (soft_rst_i), .cpu_rst_i (cpu_rst_i),
        .core_rst_o (core_rst_o), .core_rdc_qlfy_o (core_rdc_qlfy_o),
        .core_rst_status_o (core_rst_status_o),
        .pipe_imem_req_i (pipe_imem_req_i), .pipe_imem_cmd_i (pipe_imem_cmd_i),
        .pipe_imem_addr_i (pipe_imem_addr_i), .pipe_imem_bl_i (pipe_imem_bl_i),
        .pipe_imem_ack_o (pipe_imem_ack_o),
        .imem_req_o (imem_req_o), .imem_cmd_o (imem_cmd_o), .imem_addr_o (imem_addr_o),
        .imem_bl_o (imem_bl_o), .imem_ack_i (imem_ack_i),
        .pipe_dmem_req_i (pipe_dmem_req_i), .pipe_dmem_cmd_i (pipe_dmem_cmd_i),
        .pipe_dmem_width_i (pipe_dmem_width_i), .pipe_dmem_addr_i (pipe_dmem_addr_i),
        .pipe_dmem_wdata_i (pipe_dmem_wdata_i), .pipe_dmem_ack_o (pipe_dmem_ack_o),
        .dmem_req_o (dmem_req_o), .dmem_cmd_o (dmem_cmd_o), .dmem_width_o (dmem_width_o),
        .dmem_addr_o (dmem_addr_o), .dmem_wdata_o (dmem_wdata_o), .dmem_ack_i (dmem_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                 // 10 ns period
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int num);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < num; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};  // One step per bit
        end
        return bits;
    endfunction

    function automatic req_rec_t random_request();
        req_rec_t    rec;
        logic [31:0] r;
        r         = rand_bits(1);
        rec.cmd   = r[0];
        r         = rand_bits(2);
        rec.width = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];  // Byte, half or word only
        rec.addr  = rand_bits(`CORE_DMEM_AWIDTH);
        rec.wdata = rand_bits(`CORE_DMEM_DWIDTH);
        r         = rand_bits(`CORE_IMEM_BSIZE);
        rec.bl    = r[`CORE_IMEM_BSIZE-1:0];
        return rec;
    endfunction

    // Memory-side view of a driven request
    function automatic req_rec_t expected_payload(input int ch, input req_rec_t drv);
        req_rec_t exp_rec;
        exp_rec = drv;                         // Carried fields pass unchanged
        if (ch == IMEM) begin
            exp_rec.width = 2'd0;              // Not on the fetch channel
            exp_rec.wdata = '0;
        end else begin
            exp_rec.bl = '0;                   // No burst on data
        end
        return exp_rec;
    endfunction

    function automatic req_rec_t observed_payload(input int ch);
        req_rec_t obs;
        obs = '0;
        if (ch == IMEM) begin
            obs.cmd  = imem_cmd_o;
            obs.addr = imem_addr_o;
            obs.bl   = imem_bl_o;
        end else begin
            obs.cmd   = dmem_cmd_o;
            obs.width = dmem_width_o;
            obs.addr  = dmem_addr_o;
            obs.wdata = dmem_wdata_o;
        end
        return obs;
    endfunction

    function automatic logic pipe_ack_of(input int ch);
        return (ch == IMEM) ? pipe_imem_ack_o : pipe_dmem_ack_o;
    endfunction

    function automatic logic mem_req_of(input int ch);
        return (ch == IMEM) ? imem_req_o : dmem_req_o;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val) begin
            report_failure($sformatf("ERR %s got=%0h expected=%0h", name, got, exp_val));
        end
    endtask

    task automatic set_pipe_req(input int ch, input logic req, input req_rec_t rec);
        if (ch == IMEM) begin
            pipe_imem_req_i  = req;
            pipe_imem_cmd_i  = rec.cmd;
            pipe_imem_addr_i = rec.addr;
            pipe_imem_bl_i   = rec.bl;
        end else begin
            pipe_dmem_req_i   = req;
            pipe_dmem_cmd_i   = rec.cmd;
            pipe_dmem_width_i = rec.width;
            pipe_dmem_addr_i  = rec.addr;
            pipe_dmem_wdata_i = rec.wdata;
        end
    endtask

    task automatic check_reset_state();
        check_value("core_rst_o", 32'(core_rst_o), 32'd1);
        check_value("core_rdc_qlfy_o", 32'(core_rdc_qlfy_o), 32'd0);
        check_value("core_rst_status_o", 32'(core_rst_status_o), 32'd1);
        check_value("imem_req_o", 32'(imem_req_o), 32'd0);
        check_value("dmem_req_o", 32'(dmem_req_o), 32'd0);
        check_value("imem_cmd_o", 32'(imem_cmd_o), 32'd0);
        check_value("dmem_cmd_o", 32'(dmem_cmd_o), 32'd0);
        check_value("pipe_imem_ack_o", 32'(pipe_imem_ack_o), 32'd0);
        check_value("pipe_dmem_ack_o", 32'(pipe_dmem_ack_o), 32'd0);
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (core_rst_o || !core_rdc_qlfy_o || core_rst_status_o) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("Timeout waiting for the core reset to release");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Entered on a falling edge
    // k counts edges after the first one that samples the request
    task automatic run_reset_pulse(input logic use_cpu);
        for (int phase = 1; phase >= 0; phase--) begin
            if (use_cpu) cpu_rst_i = phase[0];
            else         soft_rst_i = phase[0];
            for (int k = 0; k < 8; k++) begin
                @(posedge clk);
                @(negedge clk);
                check_value("core_rst_o", 32'(core_rst_o),
                            32'(phase[0] ? (k >= RST_DLY) : (k < RST_DLY)));
                check_value("core_rdc_qlfy_o", 32'(core_rdc_qlfy_o),
                            32'(phase[0] ? (k < QLFY_DLY) : (k > RST_DLY)));
                check_value("core_rst_status_o", 32'(core_rst_status_o),
                            32'(phase[0] ? (k >= STATUS_DLY) : (k < STATUS_DLY)));
            end
        end
    endtask

    // ----------------------------------------
    // Pipeline driver and memory model
    // ----------------------------------------

    task automatic drive_requests(input int ch, input int num, input int gap_bits);
        req_rec_t rec;
        int       gap;
        int       waited;
        rec = '0;
        for (int i = 0; i < num; i++) begin
            gap = int'(rand_bits(gap_bits));
            if (gap > 0) begin
                set_pipe_req(ch, 1'b0, rec);
                repeat (gap) @(negedge clk);
            end
            rec = random_request();
            set_pipe_req(ch, 1'b1, rec);
            waited = 0;
            while (!pipe_ack_of(ch)) begin
                if (waited == WAIT_LIMIT) begin
                    report_failure("Timeout waiting for the slice to accept a request");
                end
                @(negedge clk);
                waited++;
            end
            exp_q[ch].push_back(rec);
            edge_q[ch].push_back(cycle_cnt + 1);   // Transfer on the coming edge
            @(negedge clk);
        end
        set_pipe_req(ch, 1'b0, rec);
    endtask

    task automatic serve_memory(input int ch);
        req_rec_t    exp_rec;
        req_rec_t    obs_rec;
        logic        ack;
        logic [31:0] r;
        int          pending;
        int          acc_edge;
        string       pfx;
        logic        rst_prev;                   // Core reset at the last falling edge
        pfx = (ch == IMEM) ? "imem" : "dmem";
        rst_prev = 1'b0;
        forever begin
            @(negedge clk);
            // Slices take the core reset on the edge after it rises
            if (rst_prev && core_rst_o) begin
                check_value({pfx, "_req_o"}, 32'(mem_req_of(ch)), 32'd0);
                check_value({"pipe_", pfx, "_ack_o"}, 32'(pipe_ack_of(ch)), 32'd0);
            end
            rst_prev = core_rst_o;
            // Occupancy from acceptances on past edges
            pending = 0;
            for (int i = 0; i < edge_q[ch].size(); i++) begin
                if (edge_q[ch][i] <= cycle_cnt) pending++;
            end
            if (pending == 2) full_seen[ch]++;
            if (ack_check_en) begin
                check_value({"pipe_", pfx, "_ack_o"}, 32'(pipe_ack_of(ch)), 32'(pending < 2));
                check_value({pfx, "_req_o"}, 32'(mem_req_of(ch)), 32'(pending != 0));
            end
            case (ack_mode[ch])
                ACK_LOW:  ack = 1'b0;
                ACK_HIGH: ack = 1'b1;
                default: begin
                    r   = rand_bits(1);
                    ack = r[0];
                end
            endcase
            if (ch == IMEM) imem_ack_i = ack;
            else            dmem_ack_i = ack;
            if (mem_req_of(ch) && ack) begin
                if (exp_q[ch].size() == 0) begin
                    report_failure({"Memory request on ", pfx, " with nothing accepted"});
                end
                exp_rec  = expected_payload(ch, exp_q[ch].pop_front());
                obs_rec  = observed_payload(ch);
                acc_edge = edge_q[ch].pop_front();
                check_value({pfx, "_cmd_o"}, 32'(obs_rec.cmd), 32'(exp_rec.cmd));
                check_value({pfx, "_addr_o"}, obs_rec.addr, exp_rec.addr);
                if (ch == DMEM) begin
                    check_value("dmem_width_o", 32'(obs_rec.width), 32'(exp_rec.width));
                    check_value("dmem_wdata_o", obs_rec.wdata, exp_rec.wdata);
                end else begin
                    check_value("imem_bl_o", 32'(obs_rec.bl), 32'(exp_rec.bl));
                end
                if (latency_check_en) begin
                    check_value({pfx, "_latency"}, 32'(cycle_cnt + 1 - acc_edge), 32'd1);
                end
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge clk);
        while (exp_q[IMEM].size() != 0 || exp_q[DMEM].size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("Timeout waiting for accepted requests to reach memory");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    initial serve_memory(IMEM);
    initial serve_memory(DMEM);

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        rst_i = 1'b1;
        soft_rst_i = 1'b0;
        cpu_rst_i = 1'b0;
        imem_ack_i = 1'b0;
        dmem_ack_i = 1'b0;
        set_pipe_req(IMEM, 1'b0, '0);
        set_pipe_req(DMEM, 1'b0, '0);
        ack_mode[IMEM] = ACK_HIGH;
        ack_mode[DMEM] = ACK_HIGH;
        full_seen[IMEM] = 0;
        full_seen[DMEM] = 0;

        // Power-up reset for 16 cycles
        for (int i = 1; i <= 16; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (i > 2) check_reset_state();    // Slices settle one edge late
        end
        rst_i = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_reset_state();                   // Core reset outlives rst_i
        wait_reset_release();

        // Sequenced reset from each request source
        run_reset_pulse(1'b0);
        run_reset_pulse(1'b1);

        // Fetch stream against an always ready memory
        @(posedge clk);
        ack_check_en = 1'b1;
        latency_check_en = 1'b1;
        @(negedge clk);
        drive_requests(IMEM, 40, 2);
        wait_drained();
        latency_check_en = 1'b0;

        // Data stream against a random ack pattern
        ack_mode[DMEM] = ACK_RANDOM;
        @(negedge clk);
        drive_requests(DMEM, 60, 1);
        wait_drained();
        if (full_seen[DMEM] == 0) report_failure("Data channel never held two requests");

        // Fetch stalls while data keeps moving
        ack_mode[IMEM] = ACK_LOW;
        @(negedge clk);
        fork
            drive_requests(IMEM, 2, 0);
            drive_requests(DMEM, 30, 1);
        join
        repeat (4) begin
            @(negedge clk);
            check_value("imem_req_o", 32'(imem_req_o), 32'd1);
            check_value("pipe_imem_ack_o", 32'(pipe_imem_ack_o), 32'd0);
        end
        @(posedge clk);
        ack_mode[IMEM] = ACK_HIGH;             // Drain the two held fetches
        wait_drained();

        @(negedge clk);
        if (imem_req_o || dmem_req_o) begin
            report_failure("Requests left at the memory side at end of run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
